// ==== include/rv_core_macros.svh ====
// ----------------------------------------
// core configuration macros: boot address,
// data width and integer register count.
// ----------------------------------------
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// first fetch address after reset.
`define RV_BOOT_ADDR 32'h0000_0000

// data and address width.
`define RV_XLEN 32

// integer register file depth.
`define RV_REG_COUNT 32

`endif

// ==== design/rv_isa_pkg.sv ====
// ----------------------------------------
// rv32i instruction-set types: major opcodes,
// branch conditions and alu functions.
// ----------------------------------------
package rv_isa_pkg;

    // major opcodes, inst[6:0].
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // branch funct3.
    typedef enum logic [2:0] {
        BEQ = 3'b000,
        BNE = 3'b001,
        BLT = 3'b100,  // signed.
        BGE = 3'b101   // signed.
    } branch_e;

    // alu functions.
    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        PASS_B = 3'd5  // lui and jump link.
    } alu_e;

endpackage

// ==== design/rv_pipe_pkg.sv ====
// ----------------------------------------
// pipeline types: fetch state and execute
// operation class.
// ----------------------------------------
package rv_pipe_pkg;

    // fetch sequencing.
    typedef enum logic [1:0] {
        REQUEST  = 2'd0,  // ready to issue a read.
        WAIT_MEM = 2'd1,  // read outstanding.
        HOLD     = 2'd2,  // instruction held for decode.
        STOPPED  = 2'd3   // waiting for a jump target.
    } fetch_state_e;

    // what execute does with an instruction.
    typedef enum logic [1:0] {
        ALU    = 2'd0,
        BRANCH = 2'd1,
        JUMP   = 2'd2,
        NONE   = 2'd3   // retires without effect.
    } exec_class_e;

endpackage

// ==== design/fetch_if.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// fetch to decode instruction channel.
// ----------------------------------------
`include "rv_core_macros.svh"

interface fetch_if;
    logic                inst_ready;      // one-cycle pulse.
    logic [`RV_XLEN-1:0] inst_code;
    logic [`RV_XLEN-1:0] cur_inst_addr;   // pc of inst_code.
    logic [`RV_XLEN-1:0] next_inst_addr;  // pc plus 4.
    logic                control_hazard;  // forward branch, predicted not taken.
    logic                next_en;         // decode can take one.

    modport fetch (
        output inst_ready, inst_code, cur_inst_addr, next_inst_addr, control_hazard,
        input  next_en
    );

    modport decode (
        input  inst_ready, inst_code, cur_inst_addr, next_inst_addr, control_hazard,
        output next_en
    );
endinterface

// ==== design/exec_if.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// decode to execute operands, plus writeback
// and redirect paths back up the pipe.
// ----------------------------------------
`include "rv_core_macros.svh"

interface exec_if;
    // ---- decode to execute ----
    logic                      valid;           // one-cycle pulse.
    logic [`RV_XLEN-1:0]       pc;
    rv_pipe_pkg::exec_class_e  op_class;
    rv_isa_pkg::alu_e          alu_op;
    rv_isa_pkg::branch_e       branch_cond;
    logic [`RV_XLEN-1:0]       rs1_val;
    logic [`RV_XLEN-1:0]       rs2_val;
    logic [`RV_XLEN-1:0]       imm;
    logic [4:0]                rd;
    logic                      use_imm;         // alu b operand is imm.
    logic                      control_hazard;  // predicted not taken.

    // ---- execute back to decode and fetch ----
    logic                      wb_en;
    logic [4:0]                wb_rd;
    logic [`RV_XLEN-1:0]       wb_data;
    logic                      jmp_en;          // redirect pulse.
    logic [`RV_XLEN-1:0]       jmp_pc;
    logic                      flush;           // wrong path, discard.

    modport decode (
        output valid, pc, op_class, alu_op, branch_cond, rs1_val, rs2_val, imm, rd,
               use_imm, control_hazard,
        input  wb_en, wb_rd, wb_data, flush
    );

    modport exec (
        input  valid, pc, op_class, alu_op, branch_cond, rs1_val, rs2_val, imm, rd,
               use_imm, control_hazard,
        output wb_en, wb_rd, wb_data, jmp_en, jmp_pc, flush
    );

    modport fetch (input jmp_en, jmp_pc, flush);
endinterface

// ==== design/inst_fetch.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// fetch stage: memory read sequencing, static
// branch prediction and redirect handling.
// ----------------------------------------
`include "rv_core_macros.svh"

module inst_fetch (
    input  logic                clk,
    input  logic                rst,
    fetch_if.fetch              fetch,
    exec_if.fetch               redirect,
    output logic                imem_read_en,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_data,
    input  logic                imem_ready
);

    rv_pipe_pkg::fetch_state_e state, state_nx;
    rv_isa_pkg::opcode_e       pred_op;
    logic [`RV_XLEN-1:0]       pc_next;     // next sequential read.
    logic [`RV_XLEN-1:0]       redir_addr;
    logic [`RV_XLEN-1:0]       pred_code;
    logic                      drop;        // outstanding read is wrong path.
    logic                      drop_nx;
    logic                      issue;
    logic                      capture;
    logic                      present;
    logic                      pred_stop;
    logic                      pred_hazard;

    // ---------------------------------------
    // static prediction on the fresh response or the held one.
    assign pred_code = (state == rv_pipe_pkg::WAIT_MEM) ? imem_data : fetch.inst_code;
    assign pred_op   = rv_isa_pkg::opcode_e'(pred_code[6:0]);
    // backward branches and jumps stop fetch.
    assign pred_stop = (pred_op == rv_isa_pkg::BRANCH && pred_code[31]) ||
                       pred_op == rv_isa_pkg::JAL || pred_op == rv_isa_pkg::JALR;
    assign pred_hazard = (pred_op == rv_isa_pkg::BRANCH) && !pred_code[31];

    assign redir_addr = redirect.jmp_en ? redirect.jmp_pc : pc_next;

    // ---------------------------------------
    always_comb begin
        state_nx = state;
        drop_nx  = drop;
        issue    = 1'b0;
        capture  = 1'b0;
        present  = 1'b0;
        case (state)
            rv_pipe_pkg::REQUEST: issue = fetch.next_en;
            rv_pipe_pkg::WAIT_MEM: begin
                if (imem_ready && (drop || redirect.flush)) begin
                    drop_nx  = 1'b0;                  // stale response, thrown away.
                    issue    = fetch.next_en;
                    state_nx = rv_pipe_pkg::REQUEST;
                end else if (imem_ready) begin
                    capture  = 1'b1;
                    present  = fetch.next_en;
                    state_nx = rv_pipe_pkg::HOLD;     // decode busy.
                end else if (redirect.flush) begin
                    drop_nx = 1'b1;                   // wait it out.
                end
            end
            rv_pipe_pkg::HOLD: begin
                if (redirect.flush) begin
                    issue    = fetch.next_en;         // held inst discarded.
                    state_nx = rv_pipe_pkg::REQUEST;
                end else begin
                    present = fetch.next_en;
                end
            end
            rv_pipe_pkg::STOPPED: begin
                if (redirect.jmp_en) begin
                    issue    = fetch.next_en;
                    state_nx = rv_pipe_pkg::REQUEST;
                end
            end
            default: state_nx = rv_pipe_pkg::REQUEST;
        endcase
        if (present) begin
            state_nx = pred_stop ? rv_pipe_pkg::STOPPED : rv_pipe_pkg::REQUEST;
        end
        if (issue) begin
            state_nx = rv_pipe_pkg::WAIT_MEM;
        end
    end

    // ---------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state                <= rv_pipe_pkg::REQUEST;
            drop                 <= 1'b0;
            imem_read_en         <= 1'b0;
            imem_addr            <= `RV_BOOT_ADDR;
            pc_next              <= `RV_BOOT_ADDR;
            fetch.inst_ready     <= 1'b0;
            fetch.control_hazard <= 1'b0;
        end else begin
            state            <= state_nx;
            drop             <= drop_nx;
            imem_read_en     <= issue;              // one pulse per read.
            fetch.inst_ready <= present;
            if (issue) begin
                imem_addr <= redir_addr;            // stable until imem_ready.
            end
            if (redirect.jmp_en) begin
                pc_next <= redirect.jmp_pc;
            end else if (capture) begin
                pc_next <= imem_addr + 4;
            end
            if (present) begin
                fetch.control_hazard <= pred_hazard;
            end
        end
    end

    // captured instruction.
    always_ff @(posedge clk) begin
        if (capture) begin
            fetch.inst_code      <= imem_data;
            fetch.cur_inst_addr  <= imem_addr;
            fetch.next_inst_addr <= imem_addr + 4;
        end
    end

endmodule

// ==== design/inst_decode.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// decode stage: register file, immediates and
// mapping to execute class and alu function.
// ----------------------------------------
`include "rv_core_macros.svh"

module inst_decode (
    input  logic     clk,
    input  logic     rst,
    fetch_if.decode  fetch,
    exec_if.decode   exec
);

    logic [`RV_XLEN-1:0]      regs [`RV_REG_COUNT];
    logic [`RV_XLEN-1:0]      inst;
    rv_isa_pkg::opcode_e      opcode;
    logic [2:0]               funct3;
    logic [`RV_XLEN-1:0]      imm_i, imm_u, imm_b, imm_j;
    logic [`RV_XLEN-1:0]      rs1_rd, rs2_rd;
    rv_pipe_pkg::exec_class_e d_class;
    rv_isa_pkg::alu_e         d_alu;
    logic [`RV_XLEN-1:0]      d_imm, d_a, d_b;
    logic                     d_use_imm;

    // x0 reads zero; same-cycle writeback is forwarded.
    function automatic logic [`RV_XLEN-1:0] read_reg(input logic [4:0]          idx,
                                                      input logic [`RV_XLEN-1:0] stored,
                                                      input logic                wb_en,
                                                      input logic [4:0]          wb_rd,
                                                      input logic [`RV_XLEN-1:0] wb_data);
        if (idx == 5'd0) begin
            return '0;
        end
        if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return stored;
    endfunction

    // ---------------------------------------
    assign inst   = fetch.inst_code;
    assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rs1_rd = read_reg(inst[19:15], regs[inst[19:15]], exec.wb_en, exec.wb_rd,
                             exec.wb_data);
    assign rs2_rd = read_reg(inst[24:20], regs[inst[24:20]], exec.wb_en, exec.wb_rd,
                             exec.wb_data);

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        d_class   = rv_pipe_pkg::NONE;   // unsupported retires as nop.
        d_alu     = rv_isa_pkg::ADD;
        d_imm     = imm_i;
        d_use_imm = 1'b0;
        d_a       = rs1_rd;
        d_b       = rs2_rd;
        case (opcode)
            rv_isa_pkg::LUI: begin
                d_class   = rv_pipe_pkg::ALU;
                d_alu     = rv_isa_pkg::PASS_B;
                d_imm     = imm_u;
                d_use_imm = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                if (funct3 == 3'b000) begin      // addi only.
                    d_class   = rv_pipe_pkg::ALU;
                    d_use_imm = 1'b1;
                end
            end
            rv_isa_pkg::OP: begin
                d_class = rv_pipe_pkg::ALU;
                case (funct3)
                    3'b000:  d_alu = inst[30] ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
                    3'b100:  d_alu = rv_isa_pkg::XOR;
                    3'b110:  d_alu = rv_isa_pkg::OR;
                    3'b111:  d_alu = rv_isa_pkg::AND;
                    default: d_class = rv_pipe_pkg::NONE;
                endcase
            end
            rv_isa_pkg::BRANCH: begin
                d_class = rv_pipe_pkg::BRANCH;
                d_imm   = imm_b;
            end
            rv_isa_pkg::JAL, rv_isa_pkg::JALR: begin
                // target is a + imm, link goes through the alu b port.
                d_class = rv_pipe_pkg::JUMP;
                d_alu   = rv_isa_pkg::PASS_B;
                d_imm   = (opcode == rv_isa_pkg::JAL) ? imm_j : imm_i;
                d_a     = (opcode == rv_isa_pkg::JAL) ? fetch.cur_inst_addr : rs1_rd;
                d_b     = fetch.next_inst_addr;
            end
            default: d_class = rv_pipe_pkg::NONE;
        endcase
    end

    // ---------------------------------------
    assign fetch.next_en = !(fetch.inst_ready || exec.valid);  // one inst per stage.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            exec.valid <= 1'b0;
        end else begin
            exec.valid <= fetch.inst_ready && !exec.flush;      // drop on flush.
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.inst_ready) begin
            exec.pc             <= fetch.cur_inst_addr;
            exec.op_class       <= d_class;
            exec.alu_op         <= d_alu;
            exec.branch_cond    <= rv_isa_pkg::branch_e'(funct3);
            exec.rs1_val        <= d_a;
            exec.rs2_val        <= d_b;
            exec.imm            <= d_imm;
            exec.rd             <= inst[11:7];
            exec.use_imm        <= d_use_imm;
            exec.control_hazard <= fetch.control_hazard;
        end
    end

    always_ff @(posedge clk) begin
        if (exec.wb_en && exec.wb_rd != 5'd0) begin
            regs[exec.wb_rd] <= exec.wb_data;
        end
    end

endmodule

// ==== design/inst_exec.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// execute stage: alu, branch resolution,
// redirect, writeback and retire report.
// ----------------------------------------
`include "rv_core_macros.svh"

module inst_exec (
    input  logic                clk,
    input  logic                rst,
    exec_if.exec                exec,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic                retire_we,
    output logic [`RV_XLEN-1:0] retire_data
);

    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] br_target;
    logic [`RV_XLEN-1:0] jp_target;
    logic                taken;
    logic                is_br;
    logic                is_jmp;
    logic                write_rd;

    assign op_b = exec.use_imm ? exec.imm : exec.rs2_val;

    always_comb begin
        case (exec.alu_op)
            rv_isa_pkg::ADD: alu_res = exec.rs1_val + op_b;
            rv_isa_pkg::SUB: alu_res = exec.rs1_val - op_b;
            rv_isa_pkg::AND: alu_res = exec.rs1_val & op_b;
            rv_isa_pkg::OR:  alu_res = exec.rs1_val | op_b;
            rv_isa_pkg::XOR: alu_res = exec.rs1_val ^ op_b;
            default:         alu_res = op_b;   // pass_b: lui, link.
        endcase
    end

    always_comb begin
        case (exec.branch_cond)
            rv_isa_pkg::BEQ: taken = exec.rs1_val == exec.rs2_val;
            rv_isa_pkg::BNE: taken = exec.rs1_val != exec.rs2_val;
            rv_isa_pkg::BLT: taken = $signed(exec.rs1_val) < $signed(exec.rs2_val);
            rv_isa_pkg::BGE: taken = $signed(exec.rs1_val) >= $signed(exec.rs2_val);
            default:         taken = 1'b0;
        endcase
    end

    // ---------------------------------------
    assign is_br     = exec.op_class == rv_pipe_pkg::BRANCH;
    assign is_jmp    = exec.op_class == rv_pipe_pkg::JUMP;
    assign write_rd  = (exec.op_class == rv_pipe_pkg::ALU || is_jmp) && exec.rd != 5'd0;
    assign br_target = taken ? exec.pc + exec.imm : exec.pc + 4;  // fall through if not.
    assign jp_target = (exec.rs1_val + exec.imm) & ~32'd1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
            exec.jmp_en  <= 1'b0;
            exec.flush   <= 1'b0;
        end else begin
            retire_valid <= exec.valid;
            retire_we    <= exec.valid && write_rd;
            // fetch waits on jumps and backward branches, whatever the outcome.
            exec.jmp_en  <= exec.valid && (is_jmp || (is_br && (taken || !exec.control_hazard)));
            // mispredicted forward branch.
            exec.flush   <= exec.valid && is_br && taken && exec.control_hazard;
        end
    end

    always_ff @(posedge clk) begin
        if (exec.valid) begin
            retire_pc   <= exec.pc;
            retire_rd   <= exec.rd;
            retire_data <= alu_res;
            exec.jmp_pc <= is_jmp ? jp_target : br_target;
        end
    end

    // register write lands with the retire report.
    assign exec.wb_en   = retire_we;
    assign exec.wb_rd   = retire_rd;
    assign exec.wb_data = retire_data;

endmodule

// ==== design/rv_core_top.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// rv32i core top: fetch, decode and execute
// wired to memory and retire ports.
// ----------------------------------------
`include "rv_core_macros.svh"

module rv_core_top (
    input  logic                clk,
    input  logic                rst,
    output logic                imem_read_en,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_data,
    input  logic                imem_ready,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic                retire_we,
    output logic [`RV_XLEN-1:0] retire_data
);

    fetch_if f_if ();  // fetch to decode.
    exec_if  x_if ();  // decode to execute, and back.

    inst_fetch inst_fetch_inst (
        .clk          (clk),
        .rst          (rst),
        .fetch        (f_if.fetch),
        .redirect     (x_if.fetch),
        .imem_read_en (imem_read_en),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .imem_ready   (imem_ready)
    );

    inst_decode inst_decode_inst (
        .clk   (clk),
        .rst   (rst),
        .fetch (f_if.decode),
        .exec  (x_if.decode)
    );

    inst_exec inst_exec_inst (
        .clk          (clk),
        .rst          (rst),
        .exec         (x_if.exec),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_we    (retire_we),
        .retire_data  (retire_data)
    );

endmodule

// ==== dv/rv_core_tb_mem.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// instruction memory model: test program
// and lcg-driven response latency.
// ----------------------------------------
`include "rv_core_macros.svh"

module rv_core_tb_mem (
    input  logic                clk,
    input  logic                rst,
    input  logic                read_en,
    input  logic [`RV_XLEN-1:0] addr,
    output logic [`RV_XLEN-1:0] data,
    output logic                ready
);

    localparam int DEPTH = 64;

    logic [31:0] rom [DEPTH];
    logic [31:0] lcg_state;
    logic [31:0] req_addr;       // address of the outstanding read.
    logic        pending;
    int          wait_left;      // cycles to the response.

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ---------------------------------------
    // rv32i encoders.
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic load_program();
        for (int i = 0; i < DEPTH; i++) begin
            rom[i] = {i[24:0], 7'h0b};             // custom-0, never reached.
        end
        rom[0]  = enc_i(5, 0, 3'b000, 1, 7'h13);     // addi x1, x0, 5.
        rom[1]  = {20'h12345, 5'd2, 7'h37};          // lui x2, 0x12345.
        rom[2]  = enc_i(-3, 0, 3'b000, 3, 7'h13);    // addi x3, x0, -3.
        rom[3]  = enc_i(0, 0, 3'b000, 4, 7'h13);     // addi x4, x0, 0.
        rom[4]  = enc_r(7'h00, 1, 4, 3'b000, 4);     // loop: add x4, x4, x1.
        rom[5]  = enc_i(-1, 1, 3'b000, 1, 7'h13);    // addi x1, x1, -1.
        rom[6]  = enc_b(-8, 0, 1, 3'b001);           // bne x1, x0, loop.
        rom[7]  = enc_b(8, 4, 4, 3'b000);            // beq x4, x4, +8, taken.
        rom[8]  = enc_i(99, 0, 3'b000, 5, 7'h13);    // wrong path.
        rom[9]  = enc_b(8, 0, 1, 3'b001);            // bne x1, x0, +8, not taken.
        rom[10] = enc_j(36, 6);                      // jal x6, sub.
        rom[11] = enc_r(7'h00, 3, 2, 3'b000, 7);     // add x7, x2, x3.
        rom[12] = enc_r(7'h20, 4, 2, 3'b000, 8);     // sub x8, x2, x4.
        rom[13] = enc_r(7'h00, 3, 2, 3'b111, 9);     // and x9, x2, x3.
        rom[14] = enc_r(7'h00, 4, 3, 3'b110, 10);    // or x10, x3, x4.
        rom[15] = enc_r(7'h00, 3, 2, 3'b100, 11);    // xor x11, x2, x3.
        rom[16] = enc_r(7'h00, 3, 2, 3'b000, 0);     // add x0, dropped.
        rom[17] = enc_i(1, 1, 3'b001, 12, 7'h13);    // slli, unsupported.
        rom[18] = enc_j(0, 0);                       // self-jump, end.
        rom[19] = enc_i(100, 6, 3'b000, 13, 7'h13);  // sub: addi x13, x6, 100.
        rom[20] = enc_i(0, 6, 3'b000, 14, 7'h67);    // jalr x14, 0(x6).
    endtask

    // ---------------------------------------
    initial begin
        ready     = 1'b0;
        data      = '0;
        pending   = 1'b0;
        wait_left = 0;
        req_addr  = '0;
        lcg_state = 32'd82418;
        load_program();
        forever begin
            @(posedge clk);
            #1;
            ready = 1'b0;                         // single-cycle pulse.
            if (!rst) begin
                pending = 1'b0;
            end else if (pending) begin
                wait_left = wait_left - 1;
                if (wait_left == 0) begin
                    ready   = 1'b1;
                    data    = rom[req_addr[7:2]];
                    pending = 1'b0;
                end
            end else if (read_en) begin
                lcg_state = lcg_next(lcg_state);
                wait_left = 1 + lcg_state[31:30];  // 1 to 4 cycles.
                req_addr  = addr;
                pending   = 1'b1;
            end
        end
    end

endmodule

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// core testbench: clock, reset, isa model,
// retire and memory protocol checks.
// ----------------------------------------
`include "rv_core_macros.svh"

module rv_core_tb;

    localparam int RUN_LIMIT = 4000;   // cycles.

    logic                clk = 1'b0;
    logic                rst = 1'b0;
    logic                imem_read_en;
    logic [`RV_XLEN-1:0] imem_addr;
    logic [`RV_XLEN-1:0] imem_data;
    logic                imem_ready;
    logic                retire_valid;
    logic [`RV_XLEN-1:0] retire_pc;
    logic [4:0]          retire_rd;
    logic                retire_we;
    logic [`RV_XLEN-1:0] retire_data;

    // ---- isa model state ----
    logic [31:0] m_regs [`RV_REG_COUNT];
    logic [31:0] m_pc;
    logic [31:0] exp_pc;
    logic [31:0] exp_data;
    logic [4:0]  exp_rd;
    logic        exp_we;
    logic        exp_self;               // self-jump retiring.
    int          end_retires = 0;
    int          flush_seen = 0;
    int          flush_expected = 0;     // taken forward branches.
    logic        outstanding = 1'b0;     // read in flight.
    logic [31:0] held_addr = '0;

    always #4 clk = ~clk;

    rv_core_top rv_core_top_inst (
        .clk          (clk),
        .rst          (rst),
        .imem_read_en (imem_read_en),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .imem_ready   (imem_ready),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_we    (retire_we),
        .retire_data  (retire_data)
    );

    rv_core_tb_mem rv_core_tb_mem (
        .clk     (clk),
        .rst     (rst),
        .read_en (imem_read_en),
        .addr    (imem_addr),
        .data    (imem_data),
        .ready   (imem_ready)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else abort_run($sformatf(
            "error: time %0d ns, %s expected 0x%08h, got 0x%08h",
            $time, name, expected, actual));
    endtask

    // ---------------------------------------
    // one rv32i instruction from the program array.
    task automatic model_step();
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] next;
        logic [2:0]  f3;
        logic        taken;
        inst     = rv_core_tb_mem.rom[m_pc[7:2]];
        f3       = inst[14:12];
        a        = m_regs[inst[19:15]];
        b        = m_regs[inst[24:20]];
        imm_i    = {{20{inst[31]}}, inst[31:20]};
        imm_b    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j    = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        next     = m_pc + 4;
        taken    = 1'b0;
        exp_pc   = m_pc;
        exp_rd   = inst[11:7];
        exp_we   = 1'b0;
        exp_data = '0;
        case (inst[6:0])
            7'h37: begin                                   // lui.
                exp_we   = 1'b1;
                exp_data = {inst[31:12], 12'h000};
            end
            7'h13: begin                                   // addi only.
                exp_we   = (f3 == 3'b000);
                exp_data = a + imm_i;
            end
            7'h33: begin
                exp_we = 1'b1;
                case (f3)
                    3'b000:  exp_data = inst[30] ? a - b : a + b;
                    3'b100:  exp_data = a ^ b;
                    3'b110:  exp_data = a | b;
                    3'b111:  exp_data = a & b;
                    default: exp_we = 1'b0;
                endcase
            end
            7'h63: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next = m_pc + imm_b;
                    if (!imm_b[31]) begin
                        flush_expected++;                  // forward, so mispredicted.
                    end
                end
            end
            7'h6f: begin                                   // jal.
                exp_we   = 1'b1;
                exp_data = m_pc + 4;
                next     = m_pc + imm_j;
            end
            7'h67: begin                                   // jalr.
                exp_we   = 1'b1;
                exp_data = m_pc + 4;
                next     = (a + imm_i) & ~32'd1;
            end
            default: exp_we = 1'b0;                        // nop.
        endcase
        if (exp_rd == 5'd0) begin
            exp_we = 1'b0;
        end
        if (exp_we) begin
            m_regs[exp_rd] = exp_data;
        end
        exp_self = (next == m_pc);
        m_pc     = next;
    endtask

    // ---------------------------------------
    // retire stream against the model.
    always @(negedge clk) begin
        if (rst && retire_valid) begin
            model_step();
            assert (!(retire_we && retire_rd == 5'd0 && retire_data != '0))
                else abort_run("register zero written with a non-zero value");
            check_value("retire_pc", exp_pc, retire_pc);
            check_value("retire_we", exp_we, retire_we);
            if (exp_we) begin
                check_value("retire_rd", exp_rd, retire_rd);
                check_value("retire_data", exp_data, retire_data);
            end
            if (exp_self) begin
                end_retires++;
            end
        end
        if (rst && rv_core_top_inst.x_if.flush) begin
            flush_seen++;
        end
    end

    // memory protocol: one read at a time, address held.
    always @(negedge clk) begin
        if (rst) begin
            if (imem_read_en) begin
                assert (!outstanding)
                    else abort_run("a new read was issued before the last one was answered");
                outstanding = 1'b1;
                held_addr   = imem_addr;
            end else if (outstanding) begin
                check_value("imem_addr", held_addr, imem_addr);
            end
            if (imem_ready) begin
                outstanding = 1'b0;
            end
        end
    end

    // ---------------------------------------
    initial begin
        int cycles;
        for (int r = 0; r < `RV_REG_COUNT; r++) begin
            m_regs[r] = '0;
        end
        m_pc = `RV_BOOT_ADDR;
        repeat (16) begin
            @(negedge clk);
            assert (!imem_read_en && !retire_valid)
                else abort_run("read or retire active during reset");
        end
        @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        assert (!imem_read_en && !retire_valid)
            else abort_run("read or retire active in the first cycle after reset");
        cycles = 0;
        while (!imem_read_en) begin
            @(negedge clk);
            cycles++;
            if (cycles > 8) begin
                abort_run("timeout: no instruction read after reset");
            end
        end
        check_value("imem_addr", `RV_BOOT_ADDR, imem_addr);   // boot fetch.
        cycles = 0;
        while (end_retires < 2) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                abort_run("timeout: the program never retired its final self-jump twice");
            end
        end
        if (flush_seen == flush_expected) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            check_value("flush count", flush_expected, flush_seen);
        end
    end

endmodule

// ==== rv_core_top.f ====
+incdir+include
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/fetch_if.sv
design/exec_if.sv
design/inst_fetch.sv
design/inst_decode.sv
design/inst_exec.sv
design/rv_core_top.sv
dv/rv_core_tb_mem.sv
dv/rv_core_tb.sv
